// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_localizer
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only when the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+tb
verilog/loc_pkg.sv
verilog/cfg_regs.sv
verilog/fft_beat_decode.sv
verilog/energy_accumulate.sv
verilog/sector_select.sv
verilog/localizer_top.sv
tb/tb_localizer.sv

// ==== tb/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

//////////////////////////////////////////////////////////////////////
// Stimulus source and reference model
//////////////////////////////////////////////////////////////////////

// x^20 + x^17 + 1, shift left, new bit enters at bit 0
function automatic logic [19:0] lfsr_next(input logic [19:0] s);
  return {s[18:0], s[19] ^ s[16]};
endfunction

// Expected direction result for one frame of spectrum beats
function automatic result_t expected_result(input logic [32*n_mics-1:0] f [frame_len],
                                            input logic [bin_w-1:0] lo,
                                            input logic [bin_w-1:0] hi,
                                            input logic [energy_w-1:0] thr);
  longint  e [n_mics];
  int      re;
  int      im;
  int      m;
  int      nb;
  int      q;
  bit      up;
  result_t r;
  for (int k = 0; k < n_mics; k++) e[k] = 0;
  for (int b = int'(lo); b <= int'(hi); b++) begin   // Inclusive band, empty if lo > hi
    for (int k = 0; k < n_mics; k++) begin
      re   = int'($signed(f[b][32*k +: sample_w]));
      im   = int'($signed(f[b][32*k+16 +: sample_w]));
      e[k] = e[k] + longint'(re < 0 ? -re : re) + longint'(im < 0 ? -im : im);
    end
  end
  m = 0;
  for (int k = 1; k < n_mics; k++) begin
    if (e[k] > e[m]) m = k;                // Lowest index keeps a tie
  end
  up = e[(m + 1) % n_mics] >= e[(m + n_mics - 1) % n_mics];
  nb = up ? (m + 1) % n_mics : (m + n_mics - 1) % n_mics;
  q  = 0;
  if (e[m] != 0) begin
    for (int k = 1; k <= 3; k++) begin
      if (4 * e[nb] >= longint'(k) * e[m]) q++;
    end
  end
  r.sector   = up ? sector_w'((4 * m + q) % 16) : sector_w'((4 * m - q + 16) % 16);
  r.loudest  = energy_w'(e[m]);
  r.detected = e[m] > longint'(thr);
  return r;
endfunction

//////////////////////////////////////////////////////////////////////
// Typed compares
//////////////////////////////////////////////////////////////////////

task automatic check_result(input string name, input result_t exp, input result_t act);
  if (act !== exp) begin
    $display("CHECK FAILED %s: expected %0d/%0d/%0b, actual %0d/%0d/%0b (sector/loudest/det)",
             name, exp.sector, exp.loudest, exp.detected,
             act.sector, act.loudest, act.detected);
    abort_run();
  end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("CHECK FAILED %s: expected data 0x%08h, actual data 0x%08h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
  if (act !== exp) begin
    $display("CHECK FAILED %s: expected resp %02b, actual resp %02b", name, exp, act);
    abort_run();
  end
endtask

`endif

// ==== tb/tb_localizer.sv ====
`timescale 1ns/1ns

module tb_localizer import loc_pkg::*; ();

  localparam int n_frames    = 22;
  localparam int cycle_limit = n_frames * 520 + 1000;

  logic                 clk_m;
  logic                 sys_rst;
  logic [32*n_mics-1:0] spec_data;
  logic                 spec_valid;
  logic                 spec_last;
  logic                 spec_ready;
  logic [3:0]           awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [31:0]          wdata;
  logic [3:0]           wstrb;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;
  logic [3:0]           araddr;
  logic                 arvalid;
  logic                 arready;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;
  logic                 result_valid;
  result_t              result;

  logic [32*n_mics-1:0] frame_mem [frame_len];  // Frame being sent
  logic [19:0]          lfsr_state;
  logic [bin_w-1:0]     cur_lo;                 // Register model
  logic [bin_w-1:0]     cur_hi;
  logic [energy_w-1:0]  cur_thr;
  result_t              exp_q [$];
  int                   due_q [$];              // Cycle of the expected pulse
  string                name_q [$];
  int                   cyc = 0;
  int                   sent_count = 0;

  localizer_top u_dut (.*);

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Run stopped at cycle %0d", cyc);
  endtask

  `include "tb_ref.svh"

  initial begin
    clk_m = 1'b0;
    forever #10 clk_m = ~clk_m;
  end

  always @(posedge clk_m) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d results still pending", cyc, exp_q.size());
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input string name, input logic [3:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    @(negedge clk_m);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready)) @(negedge clk_m);
    @(negedge clk_m);                          // Taken on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk_m);
    check_resp(name, exp_resp, bresp);
    if (exp_resp == resp_okay) begin
      case (addr)
        addr_band_lo: cur_lo = data[bin_w-1:0];
        addr_band_hi: cur_hi = data[bin_w-1:0];
        default:      cur_thr = data[energy_w-1:0];
      endcase
    end
  endtask

  task automatic read_check(input string name, input logic [3:0] addr,
                            input logic [31:0] exp_data);
    @(negedge clk_m);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk_m);
    @(negedge clk_m);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_m);
    check_resp(name, resp_okay, rresp);
    check_word(name, exp_data, rdata);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Spectrum frames
  //////////////////////////////////////////////////////////////////////

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic fill_random_frame();
    logic [3:0]  sh [n_mics];
    logic [31:0] v;
    for (int k = 0; k < n_mics; k++) begin
      take_bits(4, v);
      sh[k] = v[3:0];                          // Lane attenuation moves the loudest mic
    end
    for (int i = 0; i < frame_len; i++) begin
      for (int k = 0; k < n_mics; k++) begin
        take_bits(32, v);
        frame_mem[i][32*k +: 16]    = $signed(v[15:0]) >>> sh[k];
        frame_mem[i][32*k+16 +: 16] = $signed(v[31:16]) >>> sh[k];
      end
    end
  endtask

  // Same amplitude in every bin, imaginary part negated
  task automatic fill_const_frame(input int a0, input int a1, input int a2, input int a3);
    int a [n_mics];
    a = '{a0, a1, a2, a3};
    for (int i = 0; i < frame_len; i++) begin
      for (int k = 0; k < n_mics; k++) begin
        frame_mem[i][32*k +: 16]    = 16'(a[k]);
        frame_mem[i][32*k+16 +: 16] = 16'(-a[k]);
      end
    end
  endtask

  task automatic send_frame(input string name);
    logic [bin_w-1:0] lo;
    logic [bin_w-1:0] hi;
    lo = cur_lo;                               // Band in force at bin 0
    hi = cur_hi;
    for (int i = 0; i < frame_len; i++) begin
      @(negedge clk_m);
      if (!spec_ready) begin
        $display("Spectrum input not ready in %s at bin %0d", name, i);
        abort_run();
      end
      spec_data  = frame_mem[i];
      spec_valid = 1'b1;
      spec_last  = (i == frame_len - 1);
    end
    exp_q.push_back(expected_result(frame_mem, lo, hi, cur_thr));
    due_q.push_back(cyc + 4);
    name_q.push_back(name);
    sent_count++;
  endtask

  task automatic end_stream();
    @(negedge clk_m);
    spec_valid = 1'b0;
    spec_last  = 1'b0;
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0) @(negedge clk_m);
    @(negedge clk_m);                          // Let the frame counter catch up
  endtask

  always @(negedge clk_m) begin : compare_results
    result_t exp_r;
    int      due;
    string   nm;
    if (result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Result pulse at cycle %0d with no frame outstanding", cyc);
        abort_run();
      end else begin
        exp_r = exp_q.pop_front();
        due   = due_q.pop_front();
        nm    = name_q.pop_front();
        if (cyc != due) begin
          $display("Result of %s came at cycle %0d instead of cycle %0d", nm, cyc, due);
          abort_run();
        end else begin
          check_result(nm, exp_r, result);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    sys_rst    = 1'b1;
    spec_data  = '0;
    spec_valid = 1'b0;
    spec_last  = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = 4'hF;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    lfsr_state = 20'd76097;
    cur_lo     = band_lo_rst;
    cur_hi     = band_hi_rst;
    cur_thr    = threshold_rst;
    repeat (16) @(posedge clk_m);
    @(negedge clk_m);
    sys_rst = 1'b0;

    read_check("reset_band_lo", addr_band_lo, 32'(band_lo_rst));
    read_check("reset_band_hi", addr_band_hi, 32'(band_hi_rst));
    read_check("reset_threshold", addr_threshold, 32'(threshold_rst));
    read_check("reset_frame_count", addr_frame_count, 32'd0);

    for (int f = 0; f < 10; f++) begin
      fill_random_frame();
      send_frame($sformatf("random_%0d", f));
      end_stream();
    end

    // Edges of the sector rule
    fill_const_frame(0, 0, 300, 0);
    send_frame("single_mic");
    end_stream();
    fill_const_frame(100, 60, 0, 60);
    send_frame("equal_neighbours");
    end_stream();
    fill_const_frame(50, 200, 200, 0);
    send_frame("equal_loudest");
    end_stream();
    fill_const_frame(0, 0, 0, 0);
    send_frame("all_zero");
    end_stream();
    fill_const_frame(100, 0, 0, 30);
    send_frame("wrap_to_15");
    end_stream();

    write_reg("wide_band_lo", addr_band_lo, 32'd0, resp_okay);
    write_reg("wide_band_hi", addr_band_hi, 32'd511, resp_okay);
    write_reg("high_threshold", addr_threshold, 32'd3000000, resp_okay);
    fill_random_frame();
    send_frame("wide_band");
    end_stream();

    // Band change lands in mid-frame
    fill_random_frame();
    fork
      send_frame("mid_write_old_band");
      begin
        repeat (200) @(negedge clk_m);
        write_reg("mid_band_lo", addr_band_lo, 32'd100, resp_okay);
        write_reg("mid_band_hi", addr_band_hi, 32'd200, resp_okay);
      end
    join
    end_stream();
    fill_random_frame();
    send_frame("mid_write_new_band");
    end_stream();

    drain_results();
    read_check("count_before_write", addr_frame_count, 32'(sent_count));
    write_reg("count_write", addr_frame_count, 32'h0000_FFFF, resp_slverr);
    read_check("count_after_write", addr_frame_count, 32'(sent_count));

    for (int f = 0; f < 4; f++) begin          // No idle beat between frames
      fill_random_frame();
      send_frame($sformatf("back_to_back_%0d", f));
    end
    end_stream();

    drain_results();
    read_check("final_frame_count", addr_frame_count, 32'(sent_count));
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog/cfg_regs.sv ====
`timescale 1ns/1ns

module cfg_regs import loc_pkg::*; (
  input  logic        clk_m,
  input  logic        sys_rst,
  // Write address and data, taken together
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  // Read channel
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // Frame pulse from the result stage
  input  logic        result_valid,
  output cfg_t        cfg
);

  logic [15:0] frame_count;   // Wraps
  logic        wr_fire;
  logic        rd_fire;
  logic [31:0] wr_merged;

  // 32-bit view of a register slot
  function automatic logic [31:0] reg_view(input logic [1:0] slot, input cfg_t c,
                                           input logic [15:0] cnt);
    case (slot)
      2'd0:    return 32'(c.band_lo);
      2'd1:    return 32'(c.band_hi);
      2'd2:    return 32'(c.threshold);
      default: return 32'(cnt);
    endcase
  endfunction

  // Byte lanes not strobed keep their old contents
  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  assign awready   = ~bvalid;
  assign wready    = ~bvalid;
  assign arready   = ~rvalid;
  assign wr_fire   = awvalid && wvalid && awready;
  assign rd_fire   = arvalid && arready;
  assign wr_merged = merge(reg_view(awaddr[3:2], cfg, frame_count), wdata, wstrb);

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      cfg    <= '{band_lo: band_lo_rst, band_hi: band_hi_rst, threshold: threshold_rst};
      bvalid <= 1'b0;
      bresp  <= resp_okay;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
      if (awaddr >= addr_frame_count) begin
        bresp <= resp_slverr;   // Counter and unmapped space
      end else begin
        bresp <= resp_okay;
        case (awaddr[3:2])
          2'd0:    cfg.band_lo   <= wr_merged[bin_w-1:0];
          2'd1:    cfg.band_hi   <= wr_merged[bin_w-1:0];
          default: cfg.threshold <= wr_merged[energy_w-1:0];
        endcase
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path and frame counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      rvalid      <= 1'b0;
      rresp       <= resp_okay;
      rdata       <= '0;
      frame_count <= '0;
    end else begin
      if (result_valid) frame_count <= frame_count + 16'd1;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= (araddr > addr_frame_count) ? resp_slverr : resp_okay;
        rdata  <= (araddr > addr_frame_count) ? 32'd0
                                               : reg_view(araddr[3:2], cfg, frame_count);
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Responses stay up until the master takes them
  a_b_hold: assert property (@(posedge clk_m) disable iff (sys_rst)
    bvalid && !bready |=> bvalid && $stable(bresp));
  a_r_hold: assert property (@(posedge clk_m) disable iff (sys_rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== verilog/energy_accumulate.sv ====
`timescale 1ns/1ns

module energy_accumulate import loc_pkg::*; (
  input  logic      clk_m,
  input  logic      sys_rst,
  input  lane_mag_t lanes,
  output energy_t   energy
);

  //////////////////////////////////////////////////////////////////////
  // Running sums
  //////////////////////////////////////////////////////////////////////

  logic [n_mics-1:0][energy_w-1:0] acc;
  logic [n_mics-1:0][energy_w:0]   acc_next;   // One guard bit
  logic [n_mics-1:0]               carry;
  logic [n_mics-1:0][energy_w-1:0] e_out;
  logic                            e_valid;

  always_comb begin
    for (int k = 0; k < n_mics; k++) begin
      acc_next[k] = {1'b0, acc[k]} + (energy_w + 1)'(lanes.mag[k]);
      carry[k]    = acc_next[k][energy_w];
    end
  end

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      acc     <= '0;
      e_valid <= 1'b0;
    end else begin
      e_valid <= lanes.valid && lanes.last;
      if (lanes.valid) begin
        for (int k = 0; k < n_mics; k++) begin
          acc[k] <= lanes.last ? '0 : acc_next[k][energy_w-1:0];   // Restart on frame end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame energies
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_m) begin
    if (lanes.valid && lanes.last) begin
      for (int k = 0; k < n_mics; k++) begin
        e_out[k] <= acc_next[k][energy_w-1:0];   // Includes the last bin
      end
    end
  end

  assign energy = '{valid: e_valid, e: e_out};

  // energy_w covers a full frame at full scale on every lane
  a_no_wrap: assert property (@(posedge clk_m) disable iff (sys_rst)
    lanes.valid |-> carry == '0);

endmodule

// ==== verilog/fft_beat_decode.sv ====
`timescale 1ns/1ns

module fft_beat_decode import loc_pkg::*; (
  input  logic                       clk_m,
  input  logic                       sys_rst,
  input  logic [32*n_mics-1:0]       spec_data,   // {im, re} per lane
  input  logic                       spec_valid,
  input  logic                       spec_last,
  output logic                       spec_ready,
  input  cfg_t                       cfg,
  output lane_mag_t                  lanes
);

  logic [bin_w-1:0]           bin_idx;
  logic [bin_w-1:0]           lo_hold;      // Band frozen for the frame
  logic [bin_w-1:0]           hi_hold;
  logic [bin_w-1:0]           lo_cur;
  logic [bin_w-1:0]           hi_cur;
  logic                       beat;
  logic                       in_band;
  logic                       out_valid;
  logic                       out_last;
  logic [n_mics-1:0][mag_w-1:0] out_mag;

  // |v| widened by one bit so that -32768 fits
  function automatic logic [mag_w-1:0] abs_ext(input logic signed [sample_w-1:0] v);
    logic signed [mag_w-1:0] wide;
    wide = mag_w'(v);
    return wide[mag_w-1] ? mag_w'(-wide) : mag_w'(wide);
  endfunction

  assign beat    = spec_valid && spec_ready;
  // First bin sees the live band, the rest see the copy taken at bin 0
  assign lo_cur  = (bin_idx == '0) ? cfg.band_lo : lo_hold;
  assign hi_cur  = (bin_idx == '0) ? cfg.band_hi : hi_hold;
  assign in_band = (bin_idx >= lo_cur) && (bin_idx <= hi_cur);

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      spec_ready <= 1'b0;
      bin_idx    <= '0;
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
    end else begin
      spec_ready <= 1'b1;   // Downstream never stalls
      out_valid  <= beat;
      out_last   <= beat && spec_last;
      if (beat) bin_idx <= spec_last ? '0 : bin_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_m) begin
    if (beat && bin_idx == '0) begin
      lo_hold <= cfg.band_lo;
      hi_hold <= cfg.band_hi;
    end
    for (int k = 0; k < n_mics; k++) begin
      out_mag[k] <= in_band ? abs_ext(spec_data[32*k +: sample_w])
                              + abs_ext(spec_data[32*k+16 +: sample_w]) : '0;
    end
  end

  assign lanes = '{valid: out_valid, last: out_last, mag: out_mag};

  // Frame boundaries from the FFT match the bin counter
  a_last_pos: assert property (@(posedge clk_m) disable iff (sys_rst)
    beat && spec_last |-> bin_idx == bin_w'(frame_len - 1));

endmodule

// ==== verilog/loc_pkg.sv ====
package loc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Array and datapath sizes
  //////////////////////////////////////////////////////////////////////

  localparam int n_mics    = 4;
  localparam int frame_len = 512;
  localparam int bin_w     = 9;          // Bin index 0..511
  localparam int sample_w  = 16;         // Signed real or imaginary part
  localparam int mag_w     = 17;         // |re| + |im| reaches 65536
  localparam int energy_w  = 26;         // 512 bins of full-scale magnitude
  localparam int sector_w  = 4;
  localparam int mic_w     = $clog2(n_mics);

  //////////////////////////////////////////////////////////////////////
  // Register map and responses
  //////////////////////////////////////////////////////////////////////

  localparam logic [3:0] addr_band_lo     = 4'h0;
  localparam logic [3:0] addr_band_hi     = 4'h4;
  localparam logic [3:0] addr_threshold   = 4'h8;
  localparam logic [3:0] addr_frame_count = 4'hC;  // Read only

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  localparam logic [bin_w-1:0]    band_lo_rst   = 9'd8;
  localparam logic [bin_w-1:0]    band_hi_rst   = 9'd40;
  localparam logic [energy_w-1:0] threshold_rst = 26'd5000;

  //////////////////////////////////////////////////////////////////////
  // Stage to stage records
  //////////////////////////////////////////////////////////////////////

  // Live configuration
  typedef struct packed {
    logic [bin_w-1:0]    band_lo;   // Inclusive
    logic [bin_w-1:0]    band_hi;   // Inclusive
    logic [energy_w-1:0] threshold;
  } cfg_t;

  // One bin, all lanes, after magnitude and band gating
  typedef struct packed {
    logic                           valid;
    logic                           last;  // Final bin of the frame
    logic [n_mics-1:0][mag_w-1:0]   mag;
  } lane_mag_t;

  // Per-microphone energy at frame end
  typedef struct packed {
    logic                            valid;
    logic [n_mics-1:0][energy_w-1:0] e;
  } energy_t;

  typedef struct packed {
    logic [sector_w-1:0] sector;
    logic [energy_w-1:0] loudest;
    logic                detected;
  } result_t;

endpackage

// ==== verilog/localizer_top.sv ====
`timescale 1ns/1ns

module localizer_top import loc_pkg::*; (
  input  logic                 clk_m,
  input  logic                 sys_rst,
  // Spectrum from the FFT
  input  logic [32*n_mics-1:0] spec_data,
  input  logic                 spec_valid,
  input  logic                 spec_last,
  output logic                 spec_ready,
  // Configuration slave
  input  logic [3:0]           awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [31:0]          wdata,
  input  logic [3:0]           wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic [3:0]           araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [31:0]          rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready,
  // Direction result
  output logic                 result_valid,
  output result_t              result
);

  cfg_t      cfg_bus;
  lane_mag_t lane_bus;
  energy_t   energy_bus;

  cfg_regs u_cfg (
    .clk_m, .sys_rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .result_valid,
    .cfg          (cfg_bus)
  );

  fft_beat_decode u_decode (
    .clk_m, .sys_rst,
    .spec_data, .spec_valid, .spec_last, .spec_ready,
    .cfg          (cfg_bus),
    .lanes        (lane_bus)
  );

  energy_accumulate u_accum (
    .clk_m, .sys_rst,
    .lanes        (lane_bus),
    .energy       (energy_bus)
  );

  sector_select u_sector (
    .clk_m, .sys_rst,
    .energy       (energy_bus),
    .cfg          (cfg_bus),
    .result_valid,
    .result
  );

endmodule

// ==== verilog/sector_select.sv ====
`timescale 1ns/1ns

module sector_select import loc_pkg::*; (
  input  logic    clk_m,
  input  logic    sys_rst,
  input  energy_t energy,
  input  cfg_t    cfg,
  output logic    result_valid,
  output result_t result
);

  localparam int ext_w = energy_w + 2;   // Room for 4x and 3x products

  // Combinational side of stage one
  logic [mic_w-1:0]    loud_idx;
  logic [energy_w-1:0] loud_e;
  logic [mic_w-1:0]    up_idx;
  logic [mic_w-1:0]    dn_idx;
  logic                up_side;
  logic [energy_w-1:0] nb_e;

  // Stage one registers
  logic                s1_valid;
  logic [mic_w-1:0]    s1_idx;
  logic [energy_w-1:0] s1_loud;
  logic                s1_up;
  logic [energy_w-1:0] s1_nb;

  // Stage two
  logic [1:0]          q;
  logic [ext_w-1:0]    nb_x4;
  logic [sector_w-1:0] base;
  logic [sector_w-1:0] sector;

  //////////////////////////////////////////////////////////////////////
  // Stage one: loudest microphone and its louder neighbour
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    loud_idx = '0;
    loud_e   = energy.e[0];
    for (int k = 1; k < n_mics; k++) begin
      if (energy.e[k] > loud_e) begin   // Strict, so the lower index keeps a tie
        loud_idx = mic_w'(k);
        loud_e   = energy.e[k];
      end
    end
    up_idx  = loud_idx + 1'b1;          // Wraps around the ring
    dn_idx  = loud_idx - 1'b1;
    up_side = energy.e[up_idx] >= energy.e[dn_idx];
    nb_e    = up_side ? energy.e[up_idx] : energy.e[dn_idx];
  end

  always_ff @(posedge clk_m) begin
    if (sys_rst) s1_valid <= 1'b0;
    else         s1_valid <= energy.valid;
  end

  always_ff @(posedge clk_m) begin
    if (energy.valid) begin
      s1_idx  <= loud_idx;
      s1_loud <= loud_e;
      s1_up   <= up_side;
      s1_nb   <= nb_e;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage two: quantize the ratio and check loudness
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    q     = '0;
    nb_x4 = {s1_nb, 2'b00};
    for (int k = 1; k <= 3; k++) begin
      if (s1_loud != '0 && nb_x4 >= ext_w'(s1_loud) * ext_w'(k)) q = q + 1'b1;
    end
    base   = {s1_idx, 2'b00};                     // Mic m sits at 4m
    sector = s1_up ? base + sector_w'(q) : base - sector_w'(q);
  end

  always_ff @(posedge clk_m) begin
    if (sys_rst) result_valid <= 1'b0;
    else         result_valid <= s1_valid;
  end

  always_ff @(posedge clk_m) begin
    if (s1_valid) begin
      result <= '{sector: sector, loudest: s1_loud, detected: s1_loud > cfg.threshold};
    end
  end

  // Frames span frame_len bins so two frame ends never touch
  a_pulse: assert property (@(posedge clk_m) disable iff (sys_rst)
    result_valid |=> !result_valid);

endmodule
